//--- l1_mau.sv
// L1 refill unit, reads only; no write, error, retry, lock or tag signals on the Wishbone side
`timescale 1ns/1ns
`default_nettype none

module l1_mau #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int LINE_WORDS = 4
) (
	input  wire logic                             wb_clk_i,
	input  wire logic                             rst_n,

	// Instruction cache port
	input  wire logic                             l1i_req_val_i,
	input  wire logic [ADDR_WIDTH-1:0]            l1i_req_addr_i,
	output logic                                  l1i_req_ack_o,
	output logic      [LINE_WORDS*DATA_WIDTH-1:0] l1i_ack_data_o,

	// Data cache port
	input  wire logic                             l1d_req_val_i,
	input  wire logic [ADDR_WIDTH-1:0]            l1d_req_addr_i,
	output logic                                  l1d_req_ack_o,
	output logic      [LINE_WORDS*DATA_WIDTH-1:0] l1d_ack_data_o,

	// Wishbone B4 pipelined master
	input  wire logic [DATA_WIDTH-1:0]            wb_dat_i,
	input  wire logic                             wb_ack_i,
	input  wire logic                             wb_stall_i,
	output logic      [ADDR_WIDTH-1:0]            wb_adr_o,
	output logic                                  wb_cyc_o,
	output logic                                  wb_stb_o,
	output logic                                  wb_sel_o
);

	localparam int LINE_WIDTH = LINE_WORDS * DATA_WIDTH;
	localparam int TAG_WIDTH  = $bits(selen_mau_pkg::mau_port_e);

	logic                     tag_push;
	selen_mau_pkg::mau_port_e tag_port;
	logic                     tag_pop;
	logic [TAG_WIDTH-1:0]     tag_head_raw;
	selen_mau_pkg::mau_port_e tag_head;
	logic                     tag_empty;
	logic                     tag_full;
	logic [LINE_WIDTH-1:0]    line_data;
	logic                     cyc_r;

	mau_req_issuer #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH),
		.LINE_WORDS (LINE_WORDS)
	) issuer (
		.wb_clk_i       (wb_clk_i),
		.rst_n          (rst_n),
		.l1i_req_val_i  (l1i_req_val_i),
		.l1i_req_addr_i (l1i_req_addr_i),
		.l1d_req_val_i  (l1d_req_val_i),
		.l1d_req_addr_i (l1d_req_addr_i),
		.ack_i_i        (l1i_req_ack_o),
		.ack_d_i        (l1d_req_ack_o),
		.wb_stall_i     (wb_stall_i),
		.tag_push_o     (tag_push),
		.tag_port_o     (tag_port),
		.wb_stb_o       (wb_stb_o),
		.wb_adr_o       (wb_adr_o)
	);

	// One slot per port, so two is enough
	mau_tag_fifo #(
		.WIDTH (TAG_WIDTH),
		.DEPTH (2)
	) tag_queue (
		.wb_clk_i    (wb_clk_i),
		.rst_n       (rst_n),
		.push_i      (tag_push),
		.push_data_i (tag_port),
		.pop_i       (tag_pop),
		.pop_data_o  (tag_head_raw),
		.empty_o     (tag_empty),
		.full_o      (tag_full)
	);

	assign tag_head = selen_mau_pkg::mau_port_e'(tag_head_raw);

	mau_ack_collector #(
		.DATA_WIDTH (DATA_WIDTH),
		.LINE_WORDS (LINE_WORDS)
	) collector (
		.wb_clk_i      (wb_clk_i),
		.rst_n         (rst_n),
		.wb_ack_i      (wb_ack_i),
		.wb_dat_i      (wb_dat_i),
		.tag_head_i    (tag_head),
		.tag_pop_o     (tag_pop),
		.l1i_req_ack_o (l1i_req_ack_o),
		.l1d_req_ack_o (l1d_req_ack_o),
		.line_data_o   (line_data)
	);

	// --------------------------------------------------------------------------
	// Bus cycle, high while any line is in flight
	// --------------------------------------------------------------------------
	// Push folded in so cyc rises together with the first strobe
	always_ff @(posedge wb_clk_i or negedge rst_n) begin
		if (!rst_n)
			cyc_r <= 1'b0;
		else
			cyc_r <= tag_push || !tag_empty;
	end

	assign wb_cyc_o       = cyc_r;
	assign wb_sel_o       = wb_stb_o;
	assign l1i_ack_data_o = line_data;
	assign l1d_ack_data_o = line_data;

	// Strobe only inside a bus cycle, and never a third line in flight
	a_stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
		wb_stb_o |-> wb_cyc_o);
	a_no_third_line: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
		tag_full |-> !tag_push);

endmodule

`default_nettype wire

//--- mau_ack_collector.sv
// Beats arrive in order, line completes on every LINE_WORDS-th ack; first beat lands in top word
`timescale 1ns/1ns
`default_nettype none

module mau_ack_collector #(
	parameter int DATA_WIDTH = 32,
	parameter int LINE_WORDS = 4
) (
	input  wire logic                                 wb_clk_i,
	input  wire logic                                 rst_n,
	input  wire logic                                 wb_ack_i,
	input  wire logic [DATA_WIDTH-1:0]                wb_dat_i,
	input  wire selen_mau_pkg::mau_port_e             tag_head_i,
	output logic                                      tag_pop_o,
	output logic                                      l1i_req_ack_o,
	output logic                                      l1d_req_ack_o,
	output logic      [LINE_WORDS*DATA_WIDTH-1:0]     line_data_o
);

	localparam int LINE_WIDTH = LINE_WORDS * DATA_WIDTH;
	localparam int CNT_W      = $clog2(LINE_WORDS);

	selen_mau_pkg::collector_state_e state;

	logic [CNT_W-1:0]      beat_cnt;
	logic [LINE_WIDTH-1:0] line;
	logic                  last_beat;
	logic                  ack_i_r;
	logic                  ack_d_r;

	// --------------------------------------------------------------------------
	// Beat counting
	// --------------------------------------------------------------------------
	assign last_beat = wb_ack_i && (state == selen_mau_pkg::COL_RECV)
		&& (beat_cnt == CNT_W'(LINE_WORDS - 1));
	assign tag_pop_o = last_beat;

	always_ff @(posedge wb_clk_i or negedge rst_n) begin
		if (!rst_n) begin
			state    <= selen_mau_pkg::COL_IDLE;
			beat_cnt <= '0;
		end else if (wb_ack_i) begin
			case (state)
				selen_mau_pkg::COL_IDLE: begin
					state    <= selen_mau_pkg::COL_RECV;
					beat_cnt <= CNT_W'(1);
				end
				selen_mau_pkg::COL_RECV: begin
					if (last_beat) begin
						state    <= selen_mau_pkg::COL_IDLE;
						beat_cnt <= '0;
					end else begin
						beat_cnt <= beat_cnt + 1'b1;
					end
				end
				default: state <= selen_mau_pkg::COL_IDLE;
			endcase
		end
	end

	// Older beats move toward the top word
	always_ff @(posedge wb_clk_i) begin
		if (wb_ack_i)
			line <= {line[LINE_WIDTH-DATA_WIDTH-1:0], wb_dat_i};
	end

	// --------------------------------------------------------------------------
	// Port acknowledge, one cycle after the pop
	// --------------------------------------------------------------------------
	always_ff @(posedge wb_clk_i or negedge rst_n) begin
		if (!rst_n) begin
			ack_i_r <= 1'b0;
			ack_d_r <= 1'b0;
		end else begin
			ack_i_r <= last_beat && (tag_head_i == selen_mau_pkg::PORT_I);
			ack_d_r <= last_beat && (tag_head_i == selen_mau_pkg::PORT_D);
		end
	end

	assign l1i_req_ack_o = ack_i_r;
	assign l1d_req_ack_o = ack_d_r;
	assign line_data_o   = line;

endmodule

`default_nettype wire

//--- mau_req_issuer.sv
// Read bursts only, one outstanding line per port; request address must be line aligned
`timescale 1ns/1ns
`default_nettype none

module mau_req_issuer #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int LINE_WORDS = 4
) (
	input  wire logic                  wb_clk_i,
	input  wire logic                  rst_n,
	input  wire logic                  l1i_req_val_i,
	input  wire logic [ADDR_WIDTH-1:0] l1i_req_addr_i,
	input  wire logic                  l1d_req_val_i,
	input  wire logic [ADDR_WIDTH-1:0] l1d_req_addr_i,
	input  wire logic                  ack_i_i,
	input  wire logic                  ack_d_i,
	input  wire logic                  wb_stall_i,
	output logic                       tag_push_o,
	output selen_mau_pkg::mau_port_e   tag_port_o,
	output logic                       wb_stb_o,
	output logic      [ADDR_WIDTH-1:0] wb_adr_o
);

	localparam int CNT_W = $clog2(LINE_WORDS);
	localparam int STEP  = DATA_WIDTH / 8;

	selen_mau_pkg::issuer_state_e state;

	logic                  out_i;
	logic                  out_d;
	logic                  elig_i;
	logic                  elig_d;
	logic                  take;
	logic                  beat;
	logic [CNT_W-1:0]      beat_cnt;
	logic [ADDR_WIDTH-1:0] addr;

	// --------------------------------------------------------------------------
	// Eligibility and arbitration, data port first
	// --------------------------------------------------------------------------
	assign elig_i = l1i_req_val_i && !out_i;
	assign elig_d = l1d_req_val_i && !out_d;
	assign take   = (state == selen_mau_pkg::ISS_IDLE) && (elig_i || elig_d);

	assign tag_push_o = take;
	assign tag_port_o = elig_d ? selen_mau_pkg::PORT_D : selen_mau_pkg::PORT_I;

	// Outstanding flags, set on issue and cleared by the line ack
	always_ff @(posedge wb_clk_i or negedge rst_n) begin
		if (!rst_n) begin
			out_i <= 1'b0;
			out_d <= 1'b0;
		end else begin
			if (ack_i_i)
				out_i <= 1'b0;
			else if (take && !elig_d)
				out_i <= 1'b1;
			if (ack_d_i)
				out_d <= 1'b0;
			else if (take && elig_d)
				out_d <= 1'b1;
		end
	end

	// --------------------------------------------------------------------------
	// Burst sequencer
	// --------------------------------------------------------------------------
	assign wb_stb_o = (state == selen_mau_pkg::ISS_BURST);
	assign beat     = wb_stb_o && !wb_stall_i;
	assign wb_adr_o = addr;

	always_ff @(posedge wb_clk_i or negedge rst_n) begin
		if (!rst_n) begin
			state    <= selen_mau_pkg::ISS_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				selen_mau_pkg::ISS_IDLE: begin
					if (take) begin
						state    <= selen_mau_pkg::ISS_BURST;
						beat_cnt <= CNT_W'(LINE_WORDS - 1);
					end
				end
				selen_mau_pkg::ISS_BURST: begin
					// Count moves only on beats the slave took
					if (beat) begin
						if (beat_cnt == '0)
							state <= selen_mau_pkg::ISS_IDLE;
						else
							beat_cnt <= beat_cnt - 1'b1;
					end
				end
				default: state <= selen_mau_pkg::ISS_IDLE;
			endcase
		end
	end

	// Word address of the next beat
	always_ff @(posedge wb_clk_i) begin
		if (take)
			addr <= elig_d ? l1d_req_addr_i : l1i_req_addr_i;
		else if (beat)
			addr <= addr + ADDR_WIDTH'(STEP);
	end

	// Stalled beat keeps strobe and address
	a_adr_hold: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
		wb_stb_o && wb_stall_i |=> wb_stb_o && $stable(wb_adr_o));

	// Collector never acks a port that has no line in flight
	a_ack_outstanding: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
		(ack_i_i |-> out_i) and (ack_d_i |-> out_d));

endmodule

`default_nettype wire

//--- mau_tag_fifo.sv
// Small circular FIFO, DEPTH must be at least 2; head word is valid only while empty_o is low
`timescale 1ns/1ns
`default_nettype none

module mau_tag_fifo #(
	parameter int WIDTH = 1,
	parameter int DEPTH = 2
) (
	input  wire logic             wb_clk_i,
	input  wire logic             rst_n,
	input  wire logic             push_i,
	input  wire logic [WIDTH-1:0] push_data_i,
	input  wire logic             pop_i,
	output logic      [WIDTH-1:0] pop_data_o,
	output logic                  empty_o,
	output logic                  full_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign empty_o    = (count == '0);
	assign full_o     = (count == CNT_W'(DEPTH));
	assign pop_data_o = mem[rd_ptr];

	// Storage
	always_ff @(posedge wb_clk_i) begin
		if (push_i)
			mem[wr_ptr] <= push_data_i;
	end

	// Pointers wrap at DEPTH, count holds on push and pop together
	always_ff @(posedge wb_clk_i or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_i)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push_i && !pop_i)
				count <= count + 1'b1;
			else if (pop_i && !push_i)
				count <= count - 1'b1;
		end
	end

	// Overflow means more lines in flight than the issuer may start
	a_no_overflow: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
		push_i |-> !full_o || pop_i);

	// Underflow means an ack burst with no burst issued
	a_no_underflow: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
		pop_i |-> !empty_o);

endmodule

`default_nettype wire

//--- selen_mau.f
selen_mau_pkg.sv
mau_tag_fifo.sv
mau_req_issuer.sv
mau_ack_collector.sv
l1_mau.sv
tb_wb_slave.sv
tb_l1_mau.sv

//--- selen_mau_pkg.sv
// Shared enums for the L1 memory access unit; all three are one bit wide, tag values follow port order
`default_nettype none

package selen_mau_pkg;

	// --------------------------------------------------------------------------
	// Port tag, travels through the tag queue
	// --------------------------------------------------------------------------
	typedef enum logic {
		PORT_I = 1'b0,
		PORT_D = 1'b1
	} mau_port_e;

	// --------------------------------------------------------------------------
	// Request issuer sequencer
	// --------------------------------------------------------------------------
	typedef enum logic {
		ISS_IDLE  = 1'b0,
		ISS_BURST = 1'b1
	} issuer_state_e;

	// --------------------------------------------------------------------------
	// Acknowledge collector
	// --------------------------------------------------------------------------
	typedef enum logic {
		COL_IDLE = 1'b0,
		COL_RECV = 1'b1
	} collector_state_e;

endpackage

`default_nettype wire

//--- tb_l1_mau.sv
// Default 32-bit widths and 4-word lines; rows run one after another, up to two lines in flight
`timescale 1ns/1ns
`default_nettype none

module tb_l1_mau;

	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int LINE_WORDS = 4;
	localparam int LINE_W     = LINE_WORDS * DATA_WIDTH;
	localparam int MODE_I     = 0;
	localparam int MODE_D     = 1;
	localparam int MODE_BOTH  = 2;
	localparam int N_ROWS     = 8;
	localparam int unsigned SEED = 32'h44898ba6;
	localparam logic [DATA_WIDTH-1:0] DATA_MASK = 32'hA5A50000;

	logic                  wb_clk_i;
	logic                  rst_n;
	logic                  l1i_req_val_i;
	logic [ADDR_WIDTH-1:0] l1i_req_addr_i;
	logic                  l1i_req_ack_o;
	logic [LINE_W-1:0]     l1i_ack_data_o;
	logic                  l1d_req_val_i;
	logic [ADDR_WIDTH-1:0] l1d_req_addr_i;
	logic                  l1d_req_ack_o;
	logic [LINE_W-1:0]     l1d_ack_data_o;
	logic [DATA_WIDTH-1:0] wb_dat_i;
	logic                  wb_ack_i;
	logic                  wb_stall_i;
	logic [ADDR_WIDTH-1:0] wb_adr_o;
	logic                  wb_cyc_o;
	logic                  wb_stb_o;
	logic                  wb_sel_o;

	// -------------------------------------------------------------------------
	// Stimulus table and scoreboard
	// -------------------------------------------------------------------------
	logic [ADDR_WIDTH-1:0] row_i_addr [N_ROWS];
	logic [ADDR_WIDTH-1:0] row_d_addr [N_ROWS];
	int                    row_mode   [N_ROWS];
	logic [ADDR_WIDTH-1:0] exp_beats  [$];
	logic [ADDR_WIDTH-1:0] beat_adr;
	// 1 marks a data port ack
	bit                    ack_log    [$];
	int                    errors;
	int                    checks;

	l1_mau #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH),
		.LINE_WORDS (LINE_WORDS)
	) UUT (
		.wb_clk_i       (wb_clk_i),
		.rst_n          (rst_n),
		.l1i_req_val_i  (l1i_req_val_i),
		.l1i_req_addr_i (l1i_req_addr_i),
		.l1i_req_ack_o  (l1i_req_ack_o),
		.l1i_ack_data_o (l1i_ack_data_o),
		.l1d_req_val_i  (l1d_req_val_i),
		.l1d_req_addr_i (l1d_req_addr_i),
		.l1d_req_ack_o  (l1d_req_ack_o),
		.l1d_ack_data_o (l1d_ack_data_o),
		.wb_dat_i       (wb_dat_i),
		.wb_ack_i       (wb_ack_i),
		.wb_stall_i     (wb_stall_i),
		.wb_adr_o       (wb_adr_o),
		.wb_cyc_o       (wb_cyc_o),
		.wb_stb_o       (wb_stb_o),
		.wb_sel_o       (wb_sel_o)
	);

	tb_wb_slave #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH),
		.SEED       (SEED)
	) slave (
		.clk_i   (wb_clk_i),
		.rst_n   (rst_n),
		.cyc_i   (wb_cyc_o),
		.stb_i   (wb_stb_o),
		.adr_i   (wb_adr_o),
		.stall_o (wb_stall_i),
		.ack_o   (wb_ack_i),
		.dat_o   (wb_dat_i)
	);

	initial begin
		wb_clk_i = 1'b0;
		forever #2 wb_clk_i = ~wb_clk_i;
	end

	task automatic check_value(input string name, input logic [LINE_W-1:0] got,
			input logic [LINE_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at time %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	// Word k from the top holds address plus 4k, XOR the data mask
	function automatic logic [LINE_W-1:0] expected_line(input logic [ADDR_WIDTH-1:0] base);
		logic [LINE_W-1:0] line;
		int                k;
		for (k = 0; k < LINE_WORDS; k++)
			line[(LINE_WORDS-1-k)*DATA_WIDTH +: DATA_WIDTH] = (base + 4 * k) ^ DATA_MASK;
		return line;
	endfunction

	task automatic set_row(input int idx, input logic [ADDR_WIDTH-1:0] i_addr,
			input logic [ADDR_WIDTH-1:0] d_addr, input int mode);
		row_i_addr[idx] = i_addr;
		row_d_addr[idx] = d_addr;
		row_mode[idx]   = mode;
	endtask

	// Raise val, wait for the ack, check the line, drop val the cycle after
	task automatic serve_port(input bit is_d, input logic [ADDR_WIDTH-1:0] addr);
		if (is_d) begin
			l1d_req_addr_i = addr;
			l1d_req_val_i  = 1'b1;
		end else begin
			l1i_req_addr_i = addr;
			l1i_req_val_i  = 1'b1;
		end
		@(negedge wb_clk_i);
		while (!(is_d ? l1d_req_ack_o : l1i_req_ack_o))
			@(negedge wb_clk_i);
		if (is_d)
			check_value("l1d_ack_data_o", l1d_ack_data_o, expected_line(addr));
		else
			check_value("l1i_ack_data_o", l1i_ack_data_o, expected_line(addr));
		@(posedge wb_clk_i);
		#1;
		if (is_d)
			l1d_req_val_i = 1'b0;
		else
			l1i_req_val_i = 1'b0;
	endtask

	// Taken beats in issue order, and every port ack pulse
	always @(negedge wb_clk_i) begin
		if (rst_n && wb_stb_o && !wb_stall_i) begin
			check_value("wb_sel_o", wb_sel_o, 1'b1);
			if (exp_beats.size() == 0) begin
				errors++;
				$display("Unexpected Wishbone beat at time %0t, address %0h", $time, wb_adr_o);
			end else begin
				beat_adr = exp_beats.pop_front();
				check_value("wb_adr_o", wb_adr_o, beat_adr);
			end
		end
		if (l1i_req_ack_o)
			ack_log.push_back(1'b0);
		if (l1d_req_ack_o)
			ack_log.push_back(1'b1);
	end

	initial begin
		int r;
		int k;
		errors         = 0;
		checks         = 0;
		rst_n          = 1'b0;
		l1i_req_val_i  = 1'b0;
		l1i_req_addr_i = '0;
		l1d_req_val_i  = 1'b0;
		l1d_req_addr_i = '0;
		set_row(0, 32'h0000_1000, 32'h0000_0000, MODE_I);
		set_row(1, 32'h0000_0000, 32'h0000_2000, MODE_D);
		set_row(2, 32'h0000_3000, 32'h0000_4000, MODE_BOTH);
		set_row(3, 32'h8000_0ff0, 32'h0000_0000, MODE_I);
		set_row(4, 32'h0001_0010, 32'h0001_0020, MODE_BOTH);
		set_row(5, 32'h0000_0000, 32'hffff_ffc0, MODE_D);
		set_row(6, 32'h1234_5670, 32'h7654_3210, MODE_BOTH);
		set_row(7, 32'h0000_0000, 32'h0000_0000, MODE_I);
		repeat (8) @(posedge wb_clk_i);
		#1;
		rst_n = 1'b1;
		@(negedge wb_clk_i);
		check_value("wb_cyc_o after reset", wb_cyc_o, 1'b0);
		check_value("wb_stb_o after reset", wb_stb_o, 1'b0);
		check_value("l1i_req_ack_o after reset", l1i_req_ack_o, 1'b0);
		check_value("l1d_req_ack_o after reset", l1d_req_ack_o, 1'b0);

		for (r = 0; r < N_ROWS; r++) begin
			ack_log.delete();
			// Data port wins, so its burst goes out first
			if (row_mode[r] != MODE_I)
				for (k = 0; k < LINE_WORDS; k++)
					exp_beats.push_back(row_d_addr[r] + 4 * k);
			if (row_mode[r] != MODE_D)
				for (k = 0; k < LINE_WORDS; k++)
					exp_beats.push_back(row_i_addr[r] + 4 * k);
			@(posedge wb_clk_i);
			#1;
			case (row_mode[r])
				MODE_I: serve_port(1'b0, row_i_addr[r]);
				MODE_D: serve_port(1'b1, row_d_addr[r]);
				default: fork
					serve_port(1'b0, row_i_addr[r]);
					serve_port(1'b1, row_d_addr[r]);
				join
			endcase
			// One more cycle so a stretched ack pulse still lands in the log
			@(posedge wb_clk_i);
			#1;
			if (row_mode[r] == MODE_BOTH) begin
				check_value("ack pulse count", ack_log.size(), 2);
				if (ack_log.size() == 2) begin
					check_value("first acked port", ack_log[0], 1'b1);
					check_value("second acked port", ack_log[1], 1'b0);
				end
			end else begin
				check_value("ack pulse count", ack_log.size(), 1);
				if (ack_log.size() == 1)
					check_value("acked port", ack_log[0], row_mode[r] == MODE_D);
			end
			check_value("beats still expected", exp_beats.size(), 0);
		end

		repeat (2) @(negedge wb_clk_i);
		check_value("wb_cyc_o when idle", wb_cyc_o, 1'b0);
		check_value("wb_stb_o when idle", wb_stb_o, 1'b0);
		$display("Run done: %0d rows, %0d checks, %0d errors", N_ROWS, checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (N_ROWS * 200) @(posedge wb_clk_i);
		$display("Timeout: rows not done after %0d cycles, %0d errors so far",
			N_ROWS * 200, errors);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_wb_slave.sv
// Read-only pipelined Wishbone slave; data is the address XOR 32'hA5A50000, acks in order only
`timescale 1ns/1ns
`default_nettype none

module tb_wb_slave #(
	parameter int          ADDR_WIDTH = 32,
	parameter int          DATA_WIDTH = 32,
	parameter int unsigned SEED       = 1
) (
	input  wire logic                  clk_i,
	input  wire logic                  rst_n,
	input  wire logic                  cyc_i,
	input  wire logic                  stb_i,
	input  wire logic [ADDR_WIDTH-1:0] adr_i,
	output logic                       stall_o,
	output logic                       ack_o,
	output logic      [DATA_WIDTH-1:0] dat_o
);

	localparam logic [DATA_WIDTH-1:0] DATA_MASK = DATA_WIDTH'(32'hA5A50000);

	logic [ADDR_WIDTH-1:0] pend_adr [$];
	int                    pend_due [$];
	int                    cycle;
	int                    last_due;
	int                    due;

	initial begin
		void'($urandom(SEED));
		stall_o  = 1'b0;
		ack_o    = 1'b0;
		dat_o    = '0;
		cycle    = 0;
		last_due = 0;
		forever begin
			// Beat is taken at the coming rising edge
			@(negedge clk_i);
			if (rst_n && cyc_i && stb_i && !stall_o) begin
				due = cycle + $urandom_range(1, 3);
				// Keep acks in order, one per cycle
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				pend_adr.push_back(adr_i);
				pend_due.push_back(due);
			end
			@(posedge clk_i);
			#1;
			cycle++;
			stall_o = rst_n && ($urandom_range(0, 3) == 0);
			ack_o   = 1'b0;
			dat_o   = '0;
			if (pend_due.size() > 0 && pend_due[0] == cycle) begin
				void'(pend_due.pop_front());
				ack_o    = 1'b1;
				dat_o    = DATA_WIDTH'(pend_adr.pop_front()) ^ DATA_MASK;
			end
		end
	end

endmodule

`default_nettype wire
